// File: verification/bridge_patterns.txt
# columns in hex: channel, command, reply byte, parity-corrupt flag, silent flag
# command bit 15 set means read; reply columns apply to reads only
0 1a5c 00 0 0
1 2301 00 0 0
3 7fff 00 0 0
2 0000 00 0 0
0 8a00 c3 0 0
1 9100 5a 0 0
2 ff00 01 0 0
3 8300 ff 0 0
2 a200 77 1 0
0 c400 00 0 1
1 8500 e8 0 0
3 b600 3c 1 0
1 d700 00 0 1

// File: src.f
source/uart_bridge_pkg.sv
source/link_rsp_if.sv
source/cmd_dispatch.sv
source/uart_link.sv
source/rsp_collect.sv
source/uart_bridge_top.sv
verification/tb_uart_bridge.sv

// File: Makefile
# Verilator build and run for the serial command bridge

VERILATOR ?= verilator
TOP       ?= tb_uart_bridge
FILELIST  ?= src.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
PASS_TEXT ?= Simulation PASSED
VFLAGS    ?= --binary --timing --assert

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run, and look for the pass line in $(LOG)"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "  help   show this list"
	@echo "variables: VERILATOR TOP FILELIST BUILD_DIR LOG PASS_TEXT VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)
	$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@if grep -q "$(PASS_TEXT)" $(LOG); then \
		echo "pass line found in $(LOG)"; \
	else \
		echo "pass line missing from $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: verification/tb_uart_bridge.sv
`default_nettype none

module tb_uart_bridge;
  timeunit 1ns;
  timeprecision 1ps;

  localparam int NUM_CH      = 4;
  localparam int CLK_HZ      = 1_600_000;
  localparam int BAUD        = 100_000;
  localparam int CPB         = CLK_HZ / BAUD;
  localparam int CH_W        = $clog2(NUM_CH);
  localparam int BIT_NS      = CPB * 20;
  localparam int START_LIMIT = 4 * CPB;
  localparam int READ_LIMIT  = 100 * CPB;

  logic                   clk;
  logic                   rst_n;
  uart_bridge_pkg::cmd_t  cmd_in;
  logic [CH_W-1:0]        cmd_ch;
  logic                   cmd_vld;
  logic                   cmd_rdy;
  logic [NUM_CH-1:0]      rx;
  logic [NUM_CH-1:0]      tx;
  logic                   read_vld;
  uart_bridge_pkg::byte_t read_data;
  logic [CH_W-1:0]        read_ch;
  logic                   read_perr;
  logic                   read_tmo;

  // one entry per pattern line
  int          p_ch  [$];
  logic [15:0] p_cmd [$];
  logic [7:0]  p_rep [$];
  bit          p_bad [$];
  bit          p_sil [$];

  bit          conc_use [NUM_CH];
  logic [15:0] conc_cmd [NUM_CH];
  logic [7:0]  conc_rep [NUM_CH];

  int seed = 32'h779a4bd2;
  int cyc;
  int test_errs;
  int n_pass;
  int n_fail;
  int addr_seen;
  int go_cyc;
  bit frames_done;

  uart_bridge_top #(
    .NUM_CH (NUM_CH),
    .CLK_HZ (CLK_HZ),
    .BAUD   (BAUD)
  ) DUT (
    .clk       (clk),
    .rst_n     (rst_n),
    .cmd_in    (cmd_in),
    .cmd_ch    (cmd_ch),
    .cmd_vld   (cmd_vld),
    .cmd_rdy   (cmd_rdy),
    .rx        (rx),
    .tx        (tx),
    .read_vld  (read_vld),
    .read_data (read_data),
    .read_ch   (read_ch),
    .read_perr (read_perr),
    .read_tmo  (read_tmo)
  );

  initial clk = 1'b0;
  always #10 clk = ~clk;

  always @(posedge clk) begin
    cyc <= cyc + 1;
  end

  task automatic expect_true(input bit cond, input string what);
    assert (cond) else begin
      $display("error at %0d ns: %s", $time, what);
      test_errs++;
    end
  endtask

  task automatic report_timeout(input string what);
    $display("timeout at %0d ns: no %s arrived in time", $time, what);
    test_errs++;
  endtask

  task automatic finish_test(input string name);
    if (test_errs == 0) begin
      n_pass++;
      $display("%s: ok", name);
    end else begin
      n_fail++;
      $display("%s: %0d errors", name, test_errs);
    end
  endtask

  task automatic load_patterns();
    int          fd;
    int          code;
    int          guard;
    logic [31:0] f_ch;
    logic [31:0] f_cmd;
    logic [31:0] f_rep;
    logic [31:0] f_bad;
    logic [31:0] f_sil;
    string       line;
    fd = $fopen("verification/bridge_patterns.txt", "r");
    if (fd == 0) begin
      $display("could not open verification/bridge_patterns.txt");
      n_fail++;
    end else begin
      guard = 0;
      while (!$feof(fd) && guard < 256) begin
        guard++;
        code = $fscanf(fd, "%h %h %h %h %h\n", f_ch, f_cmd, f_rep, f_bad, f_sil);
        if (code == 5) begin
          p_ch.push_back(int'(f_ch));
          p_cmd.push_back(f_cmd[15:0]);
          p_rep.push_back(f_rep[7:0]);
          p_bad.push_back(f_bad[0]);
          p_sil.push_back(f_sil[0]);
        end else begin
          // comment or blank line
          code = $fgets(line, fd);
        end
      end
      $fclose(fd);
      if (p_ch.size() == 0) begin
        $display("the pattern file holds no test lines");
        n_fail++;
      end
    end
  endtask

  task automatic wait_ready(input int ch);
    int n;
    n = 0;
    @(negedge clk);
    cmd_ch = CH_W'(ch);
    @(negedge clk);
    while (!cmd_rdy && n < READ_LIMIT) begin
      @(negedge clk);
      n++;
    end
    if (!cmd_rdy) begin
      report_timeout($sformatf("cmd_rdy on ch %0d", ch));
    end
  endtask

  task automatic send_cmd(input int ch, input logic [15:0] cmd);
    wait_ready(ch);
    cmd_in  = cmd;
    cmd_vld = 1'b1;
    @(negedge clk);
    cmd_vld = 1'b0;
    expect_true(!cmd_rdy, "cmd_rdy low the cycle after acceptance");
  endtask

  // decode one frame from tx, sampled mid-bit on falling edges
  task automatic get_frame(input int ch, output logic [7:0] data, output time t_stop);
    int   n;
    logic par;
    n      = 0;
    data   = '0;
    t_stop = $time;
    while (tx[ch] && n < START_LIMIT) begin
      @(negedge clk);
      n++;
    end
    if (tx[ch]) begin
      report_timeout($sformatf("start bit on tx%0d", ch));
    end else begin
      repeat (CPB / 2) @(negedge clk);
      expect_true(!tx[ch], "start bit low at mid-bit");
      for (int i = 0; i < 8; i++) begin
        repeat (CPB) @(negedge clk);
        data[i] = tx[ch];
      end
      repeat (CPB) @(negedge clk);
      par = tx[ch];
      expect_true((^data ^ par) == 1'b1, $sformatf("odd parity on tx%0d", ch));
      repeat (CPB) @(negedge clk);
      expect_true(tx[ch], $sformatf("stop bit high on tx%0d", ch));
      t_stop = $time;
    end
  endtask

  task automatic send_reply(input int ch, input logic [7:0] data, input bit bad,
                            input int gap);
    logic [10:0] frame;
    frame = {1'b1, (~^data) ^ bad, data, 1'b0};
    repeat (gap * CPB) @(negedge clk);
    for (int i = 0; i < 11; i++) begin
      rx[ch] = frame[i];
      repeat (CPB) @(negedge clk);
    end
    rx[ch] = 1'b1;
  endtask

  task automatic watch_quiet(input int ch);
    logic [NUM_CH-1:0] others;
    int                n;
    others = ~(NUM_CH'(1) << ch);
    n      = 0;
    while (!frames_done && n < READ_LIMIT) begin
      @(negedge clk);
      n++;
      expect_true((tx & others) == others, "unused tx lines stay high");
      expect_true(!cmd_rdy, "cmd_rdy low while the link is busy");
    end
  endtask

  task automatic wait_read(output bit seen);
    int n;
    n = 0;
    @(negedge clk);
    while (!read_vld && n < READ_LIMIT) begin
      @(negedge clk);
      n++;
    end
    seen = read_vld;
    if (!seen) begin
      report_timeout("read_vld");
    end
  endtask

  task automatic run_one(input int idx);
    int          ch;
    int          gap;
    logic [15:0] cmd;
    logic [7:0]  b0;
    logic [7:0]  b1;
    logic [7:0]  want;
    time         t_stop;
    time         t_dummy;
    bit          seen;
    ch          = p_ch[idx];
    cmd         = p_cmd[idx];
    want        = p_sil[idx] ? 8'h00 : p_rep[idx];
    test_errs   = 0;
    frames_done = 1'b0;
    send_cmd(ch, cmd);
    if (!cmd[15]) begin
      fork
        watch_quiet(ch);
        begin
          get_frame(ch, b0, t_dummy);
          get_frame(ch, b1, t_dummy);
          frames_done = 1'b1;
        end
      join
      expect_true(b0 == cmd[15:8], $sformatf("address byte %h, expected %h", b0, cmd[15:8]));
      expect_true(b1 == cmd[7:0], $sformatf("data byte %h, expected %h", b1, cmd[7:0]));
      repeat (2 * CPB) begin
        @(negedge clk);
        expect_true(tx[ch], "tx idle after the second frame");
      end
    end else begin
      gap = {$random(seed)} % 16;
      fork
        watch_quiet(ch);
        begin
          get_frame(ch, b0, t_stop);
          frames_done = 1'b1;
          if (!p_sil[idx]) begin
            // reply starts once the link has left its stop bit
            repeat (CPB / 2) @(negedge clk);
            send_reply(ch, p_rep[idx], p_bad[idx], gap);
          end
        end
        begin
          wait_read(seen);
          if (seen) begin
            expect_true(read_ch == CH_W'(ch), $sformatf("read_ch %0d, expected %0d", read_ch, ch));
            expect_true(read_data == want, $sformatf("read_data %h, expected %h", read_data, want));
            expect_true(read_perr == (p_bad[idx] && !p_sil[idx]), "read_perr");
            expect_true(read_tmo == p_sil[idx], "read_tmo");
            if (p_sil[idx]) begin
              // t_stop is mid stop bit, the timeout counts from its end
              expect_true($time - t_stop >= time'(32 * BIT_NS + BIT_NS / 2),
                          "timeout reported too early");
            end
            repeat (2 * CPB) begin
              @(negedge clk);
              expect_true(!read_vld, "a single read_vld pulse");
            end
          end
        end
      join
      expect_true(b0 == cmd[15:8], $sformatf("address byte %h, expected %h", b0, cmd[15:8]));
    end
    finish_test($sformatf("pattern %0d ch %0d cmd %h", idx, ch, cmd));
  endtask

  task automatic answer_read(input int ch, input int want);
    logic [7:0] b;
    time        t;
    int         n;
    n = 0;
    if (conc_use[ch]) begin
      get_frame(ch, b, t);
      expect_true(b == conc_cmd[ch][15:8], "address byte on a concurrent read");
      // last address frame sets the common reply time
      if (addr_seen == want - 1) begin
        go_cyc = cyc + CPB;
      end
      addr_seen++;
      while ((addr_seen < want || cyc < go_cyc) && n < READ_LIMIT) begin
        @(negedge clk);
        n++;
      end
      if (addr_seen < want || cyc < go_cyc) begin
        report_timeout("address frames on the other channels");
      end
      send_reply(ch, conc_rep[ch], 1'b0, 0);
    end
  endtask

  task automatic collect_reads(input int want);
    bit got [NUM_CH];
    int n_got;
    int n;
    int last_cyc;
    n_got    = 0;
    n        = 0;
    last_cyc = 0;
    for (int c = 0; c < NUM_CH; c++) begin
      got[c] = 1'b0;
    end
    while (n_got < want && n < READ_LIMIT) begin
      @(negedge clk);
      n++;
      if (conc_use[cmd_ch] && !got[cmd_ch]) begin
        expect_true(!cmd_rdy, $sformatf("cmd_rdy low on ch %0d before its reply", cmd_ch));
      end
      if (read_vld) begin
        expect_true(conc_use[read_ch] && !got[read_ch],
                    $sformatf("unexpected reply on ch %0d", read_ch));
        expect_true(read_data == conc_rep[read_ch],
                    $sformatf("read_data %h, expected %h", read_data, conc_rep[read_ch]));
        expect_true(!read_perr && !read_tmo, "no error flags on a clean reply");
        expect_true(n_got == 0 || cyc - last_cyc >= 2, "read_vld pulses two cycles apart");
        last_cyc     = cyc;
        got[read_ch] = 1'b1;
        n_got++;
      end
      // sweep cmd_ch so every busy channel gets looked at
      cmd_ch = CH_W'((int'(cmd_ch) + 1) % NUM_CH);
    end
    if (n_got < want) begin
      report_timeout("reply on every concurrent channel");
    end
  endtask

  task automatic run_concurrent();
    int want;
    want      = 0;
    test_errs = 0;
    addr_seen = 0;
    go_cyc    = 0;
    for (int c = 0; c < NUM_CH; c++) begin
      conc_use[c] = 1'b0;
    end
    foreach (p_ch[i]) begin
      if (p_cmd[i][15] && !p_bad[i] && !p_sil[i] && !conc_use[p_ch[i]]) begin
        conc_use[p_ch[i]] = 1'b1;
        conc_cmd[p_ch[i]] = p_cmd[i];
        conc_rep[p_ch[i]] = p_rep[i];
        want++;
      end
    end
    if (want < 2) begin
      $display("the pattern file has fewer than two clean reads on distinct channels");
      test_errs++;
    end else begin
      fork
        begin
          for (int c = 0; c < NUM_CH; c++) begin
            if (conc_use[c]) begin
              send_cmd(c, conc_cmd[c]);
            end
          end
          collect_reads(want);
        end
        answer_read(0, want);
        answer_read(1, want);
        answer_read(2, want);
        answer_read(3, want);
      join
      for (int c = 0; c < NUM_CH; c++) begin
        if (conc_use[c]) begin
          wait_ready(c);
        end
      end
    end
    finish_test("concurrent reads");
  endtask

  initial begin
    rst_n     = 1'b0;
    cmd_in    = '0;
    cmd_ch    = '0;
    cmd_vld   = 1'b0;
    rx        = '1;
    n_pass    = 0;
    n_fail    = 0;
    test_errs = 0;
    repeat (16) begin
      @(negedge clk);
      expect_true(tx == '1 && cmd_rdy && !read_vld, "reset values during reset");
    end
    rst_n = 1'b1;
    repeat (4) begin
      @(negedge clk);
      expect_true(tx == '1 && cmd_rdy && !read_vld, "reset values after reset");
    end
    finish_test("reset state");
    load_patterns();
    foreach (p_ch[i]) begin
      run_one(i);
    end
    if (p_ch.size() > 0) begin
      run_concurrent();
    end
    $display("tests passed %0d, failed %0d", n_pass, n_fail);
    if (n_fail == 0) begin
      $display("Simulation PASSED");
    end else begin
      $display("Simulation FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: source/uart_bridge_top.sv
`default_nettype none

module uart_bridge_top #(
  parameter  int NUM_CH = 4,
  parameter  int CLK_HZ = 50_000_000,
  parameter  int BAUD   = 115_200,
  localparam int CH_W   = (NUM_CH > 1) ? $clog2(NUM_CH) : 1
) (
  input  logic                   clk,
  input  logic                   rst_n,
  input  uart_bridge_pkg::cmd_t  cmd_in,
  input  logic [CH_W-1:0]        cmd_ch,
  input  logic                   cmd_vld,
  output logic                   cmd_rdy,
  input  logic [NUM_CH-1:0]      rx,
  output logic [NUM_CH-1:0]      tx,
  output logic                   read_vld,
  output uart_bridge_pkg::byte_t read_data,
  output logic [CH_W-1:0]        read_ch,
  output logic                   read_perr,
  output logic                   read_tmo
);

  localparam int CLKS_PER_BIT = CLK_HZ / BAUD;

  logic [NUM_CH-1:0]     link_start;
  logic [NUM_CH-1:0]     link_busy;
  uart_bridge_pkg::cmd_t link_cmd;

  link_rsp_if rsp_if [NUM_CH] ();

  cmd_dispatch #(
    .NUM_CH (NUM_CH)
  ) u_dispatch (
    .clk        (clk),
    .rst_n      (rst_n),
    .cmd_in     (cmd_in),
    .cmd_ch     (cmd_ch),
    .cmd_vld    (cmd_vld),
    .link_busy  (link_busy),
    .cmd_rdy    (cmd_rdy),
    .link_start (link_start),
    .link_cmd   (link_cmd)
  );

  for (genvar g = 0; g < NUM_CH; g++) begin : g_link
    uart_link #(
      .CLKS_PER_BIT (CLKS_PER_BIT)
    ) u_link (
      .clk   (clk),
      .rst_n (rst_n),
      .start (link_start[g]),
      .cmd   (link_cmd),
      .rx    (rx[g]),
      .tx    (tx[g]),
      .busy  (link_busy[g]),
      .rsp   (rsp_if[g])
    );
  end

  rsp_collect #(
    .NUM_CH (NUM_CH)
  ) u_collect (
    .clk       (clk),
    .rst_n     (rst_n),
    .rsp       (rsp_if),
    .read_vld  (read_vld),
    .read_data (read_data),
    .read_ch   (read_ch),
    .read_perr (read_perr),
    .read_tmo  (read_tmo)
  );

endmodule

`default_nettype wire

// File: source/rsp_collect.sv
`default_nettype none

module rsp_collect #(
  parameter  int NUM_CH = 4,
  localparam int CH_W   = (NUM_CH > 1) ? $clog2(NUM_CH) : 1
) (
  input  logic                   clk,
  input  logic                   rst_n,
  link_rsp_if.collector          rsp [NUM_CH],
  output logic                   read_vld,
  output uart_bridge_pkg::byte_t read_data,
  output logic [CH_W-1:0]        read_ch,
  output logic                   read_perr,
  output logic                   read_tmo
);

  uart_bridge_pkg::byte_t data_arr [NUM_CH];

  logic [NUM_CH-1:0] req;
  logic [NUM_CH-1:0] perr_vec;
  logic [NUM_CH-1:0] tmo_vec;
  logic [NUM_CH-1:0] taken_q;
  logic [CH_W-1:0]   last_q;
  logic [CH_W-1:0]   pick;
  logic              pick_hit;
  logic              go;

  for (genvar i = 0; i < NUM_CH; i++) begin : g_port
    assign req[i]             = rsp[i].rsp_vld;
    assign data_arr[i]        = rsp[i].rsp_data;
    assign perr_vec[i]        = rsp[i].rsp_perr;
    assign tmo_vec[i]         = rsp[i].rsp_tmo;
    assign rsp[i].rsp_taken   = taken_q[i];
  end

  // first requester after the one served last
  always_comb begin : pick_next
    int cand;
    pick_hit = 1'b0;
    pick     = last_q;
    for (int k = 1; k <= NUM_CH; k++) begin
      cand = (int'(last_q) + k) % NUM_CH;
      if (!pick_hit && req[cand]) begin
        pick_hit = 1'b1;
        pick     = CH_W'(cand);
      end
    end
  end

  // served link still shows rsp_vld during its taken cycle
  assign go = pick_hit & ~read_vld;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      read_vld <= 1'b0;
      taken_q  <= '0;
      last_q   <= CH_W'(NUM_CH - 1);
    end else begin
      read_vld <= go;
      taken_q  <= go ? (NUM_CH'(1) << pick) : '0;
      if (go) begin
        last_q <= pick;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (go) begin
      read_data <= data_arr[pick];
      read_ch   <= pick;
      read_perr <= perr_vec[pick];
      read_tmo  <= tmo_vec[pick];
    end
  end

endmodule

`default_nettype wire

// File: source/uart_link.sv
`default_nettype none

module uart_link #(
  parameter int CLKS_PER_BIT = 434
) (
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic                  start,
  input  uart_bridge_pkg::cmd_t cmd,
  input  logic                  rx,
  output logic                  tx,
  output logic                  busy,
  link_rsp_if.link              rsp
);

  localparam int CNT_W = $clog2(CLKS_PER_BIT + 1);
  localparam int IDX_W = $clog2(uart_bridge_pkg::TMO_BITS + 1);

  localparam logic [CNT_W-1:0] CNT_LAST = CNT_W'(CLKS_PER_BIT - 1);
  localparam logic [CNT_W-1:0] CNT_MID  = CNT_W'(CLKS_PER_BIT / 2 - 1);
  localparam logic [IDX_W-1:0] IDX_STOP = IDX_W'(uart_bridge_pkg::FRAME_BITS - 1);
  localparam logic [IDX_W-1:0] IDX_PAR  = IDX_W'(uart_bridge_pkg::FRAME_BITS - 2);
  localparam logic [IDX_W-1:0] IDX_TMO  = IDX_W'(uart_bridge_pkg::TMO_BITS - 1);

  uart_bridge_pkg::link_state_t state;
  uart_bridge_pkg::cmd_t        cmd_q;
  uart_bridge_pkg::frame_t      tx_sr;
  uart_bridge_pkg::byte_t       rx_sr;

  logic [CNT_W-1:0] cnt;
  logic [IDX_W-1:0] bit_idx;
  logic             bit_end;
  logic             mid_bit;
  logic             rx_meta;
  logic             rx_sync;
  logic             rx_prev;
  logic             rx_fall;
  logic             tmo_hit;
  logic             data_smp;
  logic             perr_q;
  logic             tmo_q;
  logic             vld_q;

  assign bit_end = cnt == CNT_LAST;
  assign mid_bit = cnt == CNT_MID;
  assign rx_fall = rx_prev & ~rx_sync;

  assign tmo_hit  = (state == uart_bridge_pkg::LS_WAIT_RSP) && !rx_fall && bit_end &&
                    (bit_idx == IDX_TMO);
  assign data_smp = (state == uart_bridge_pkg::LS_RECV) && mid_bit &&
                    (bit_idx != '0) && (bit_idx < IDX_PAR);

  assign tx   = tx_sr[0];
  // start counts so the dispatcher sees the channel taken at once
  assign busy = start | (state != uart_bridge_pkg::LS_IDLE);

  assign rsp.rsp_vld  = vld_q;
  assign rsp.rsp_data = rx_sr;
  assign rsp.rsp_perr = perr_q;
  assign rsp.rsp_tmo  = tmo_q;

  // two-stage sync, then one more flop for the edge
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      rx_meta <= 1'b1;
      rx_sync <= 1'b1;
      rx_prev <= 1'b1;
    end else begin
      rx_meta <= rx;
      rx_sync <= rx_meta;
      rx_prev <= rx_sync;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state   <= uart_bridge_pkg::LS_IDLE;
      cnt     <= '0;
      bit_idx <= '0;
      tx_sr   <= '1;
      perr_q  <= 1'b0;
      tmo_q   <= 1'b0;
      vld_q   <= 1'b0;
    end else begin
      case (state)
        uart_bridge_pkg::LS_IDLE: begin
          if (start) begin
            state   <= uart_bridge_pkg::LS_SEND_ADDR;
            tx_sr   <= uart_bridge_pkg::build_frame(cmd[15:8]);
            cnt     <= '0;
            bit_idx <= '0;
            perr_q  <= 1'b0;
            tmo_q   <= 1'b0;
          end
        end
        uart_bridge_pkg::LS_SEND_ADDR, uart_bridge_pkg::LS_SEND_DATA: begin
          if (!bit_end) begin
            cnt <= cnt + 1'b1;
          end else if (bit_idx != IDX_STOP) begin
            cnt     <= '0;
            bit_idx <= bit_idx + 1'b1;
            tx_sr   <= {1'b1, tx_sr[uart_bridge_pkg::FRAME_BITS-1:1]};
          end else begin
            cnt     <= '0;
            bit_idx <= '0;
            tx_sr   <= '1;
            if (state == uart_bridge_pkg::LS_SEND_DATA) begin
              state <= uart_bridge_pkg::LS_IDLE;
            end else if (cmd_q[uart_bridge_pkg::CMD_RD_BIT]) begin
              state <= uart_bridge_pkg::LS_WAIT_RSP;
            end else begin
              // write: data frame follows with no gap
              state <= uart_bridge_pkg::LS_SEND_DATA;
              tx_sr <= uart_bridge_pkg::build_frame(cmd_q[7:0]);
            end
          end
        end
        uart_bridge_pkg::LS_WAIT_RSP: begin
          if (rx_fall) begin
            state   <= uart_bridge_pkg::LS_RECV;
            cnt     <= '0;
            bit_idx <= '0;
          end else if (tmo_hit) begin
            state <= uart_bridge_pkg::LS_HOLD;
            tmo_q <= 1'b1;
            vld_q <= 1'b1;
          end else if (bit_end) begin
            cnt     <= '0;
            bit_idx <= bit_idx + 1'b1;
          end else begin
            cnt <= cnt + 1'b1;
          end
        end
        uart_bridge_pkg::LS_RECV: begin
          if (mid_bit && bit_idx == IDX_PAR) begin
            // odd count of ones over data and parity is good
            perr_q <= ~(^{rx_sr, rx_sync});
          end
          if (mid_bit && bit_idx == IDX_STOP) begin
            state <= uart_bridge_pkg::LS_HOLD;
            vld_q <= 1'b1;
          end else if (bit_end) begin
            cnt     <= '0;
            bit_idx <= bit_idx + 1'b1;
          end else begin
            cnt <= cnt + 1'b1;
          end
        end
        uart_bridge_pkg::LS_HOLD: begin
          if (rsp.rsp_taken) begin
            state <= uart_bridge_pkg::LS_IDLE;
            vld_q <= 1'b0;
          end
        end
        default: begin
          state <= uart_bridge_pkg::LS_IDLE;
        end
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (start && state == uart_bridge_pkg::LS_IDLE) begin
      cmd_q <= cmd;
    end
    // lsb arrives first
    if (tmo_hit) begin
      rx_sr <= '0;
    end else if (data_smp) begin
      rx_sr <= {rx_sync, rx_sr[7:1]};
    end
  end

endmodule

`default_nettype wire

// File: source/cmd_dispatch.sv
`default_nettype none

module cmd_dispatch #(
  parameter  int NUM_CH = 4,
  localparam int CH_W   = (NUM_CH > 1) ? $clog2(NUM_CH) : 1
) (
  input  logic                  clk,
  input  logic                  rst_n,
  input  uart_bridge_pkg::cmd_t cmd_in,
  input  logic [CH_W-1:0]       cmd_ch,
  input  logic                  cmd_vld,
  input  logic [NUM_CH-1:0]     link_busy,
  output logic                  cmd_rdy,
  output logic [NUM_CH-1:0]     link_start,
  output uart_bridge_pkg::cmd_t link_cmd
);

  logic ch_ok;
  logic accept;

  // channel numbers past NUM_CH are never ready
  assign ch_ok   = int'(cmd_ch) < NUM_CH;
  assign cmd_rdy = ch_ok ? ~link_busy[cmd_ch] : 1'b0;
  assign accept  = cmd_vld & cmd_rdy;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      link_start <= '0;
    end else if (accept) begin
      link_start <= NUM_CH'(1) << cmd_ch;
    end else begin
      link_start <= '0;
    end
  end

  always_ff @(posedge clk) begin
    if (accept) begin
      link_cmd <= cmd_in;
    end
  end

endmodule

`default_nettype wire

// File: source/link_rsp_if.sv
`default_nettype none

interface link_rsp_if;

  logic                   rsp_vld;
  uart_bridge_pkg::byte_t rsp_data;
  logic                   rsp_perr;
  logic                   rsp_tmo;
  // one cycle, from the collector
  logic                   rsp_taken;

  modport link (
    output rsp_vld,
    output rsp_data,
    output rsp_perr,
    output rsp_tmo,
    input  rsp_taken
  );

  modport collector (
    input  rsp_vld,
    input  rsp_data,
    input  rsp_perr,
    input  rsp_tmo,
    output rsp_taken
  );

endinterface

`default_nettype wire

// File: source/uart_bridge_pkg.sv
`default_nettype none

package uart_bridge_pkg;

  // host command: {rd, addr[6:0], wdata[7:0]}
  typedef logic [15:0] cmd_t;
  typedef logic [7:0]  byte_t;
  typedef logic [10:0] frame_t;

  localparam int CMD_RD_BIT = 15;

  // start, 8 data lsb first, odd parity, stop
  localparam int FRAME_BITS = 11;

  // bit times a read reply may take to start
  localparam int TMO_BITS = 32;

  typedef enum logic [2:0] {
    LS_IDLE,
    LS_SEND_ADDR,
    LS_SEND_DATA,
    LS_WAIT_RSP,
    LS_RECV,
    LS_HOLD
  } link_state_t;

  // shifted out from bit 0 upward
  function automatic frame_t build_frame(input byte_t data);
    build_frame = {1'b1, ~^data, data, 1'b0};
  endfunction

endpackage

`default_nettype wire
